/* bench/sm83_bottom_checker.sv */
`timescale 1ns/1ps

`include "sm83_defines.svh"

module sm83_bottom_checker (
	input  logic               clk,
	input  logic               rst_n,
	input  addr_pkg::step_op_t step_op,
	input  logic               pair_step,
	input  logic               pc_load,
	input  addr_pkg::addr_t    pc_load_val,
	input  logic               bus_disable,
	input  irq_pkg::irq_mask_t irq_trig,
	input  logic               ie_wr,
	input  irq_pkg::data_t     data_in,
	input  logic               rd,
	input  logic               irq_enable,
	input  logic               ime,
	input  addr_pkg::addr_t    addr,
	input  irq_pkg::irq_mask_t irq_ack,
	input  logic               irq_pending,
	input  logic               irq_taken,
	input  logic               ie_hit,
	input  irq_pkg::data_t     ie_rd_data,
	output int                 check_count,
	output int                 error_count
);

	addr_pkg::addr_t    pc_m;  // Model program counter
	irq_pkg::irq_mask_t ie_m;
	irq_pkg::irq_mask_t if_m;
	int                 checks = 0;
	int                 errors = 0;

	assign check_count = checks;
	assign error_count = errors;

	// Byte-wise step, high byte moves on a low wrap or in pair mode
	function automatic addr_pkg::addr_t step_addr(input addr_pkg::addr_t a,
			input addr_pkg::step_op_t op, input logic pair);
		logic [7:0] lo;
		logic [7:0] hi;
		logic       wrap;
		lo   = a[7:0];
		hi   = a[15:8];
		wrap = 1'b0;
		if (op == addr_pkg::STEP_INC) begin
			wrap = (lo == 8'hFF);
			lo   = lo + 8'd1;
			if (wrap || pair) begin
				hi = hi + 8'd1;
			end
		end else if (op == addr_pkg::STEP_DEC) begin
			wrap = (lo == 8'h00);
			lo   = lo - 8'd1;
			if (wrap || pair) begin
				hi = hi - 8'd1;
			end
		end
		return {hi, lo};
	endfunction

	// -1 when no flag is set
	function automatic int lowest_index(input irq_pkg::irq_mask_t m);
		for (int i = 0; i < `SM83_IRQ_N; i++) begin
			if (m[i]) begin
				return i;
			end
		end
		return -1;
	endfunction

	task automatic check_field(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %0t ns: %s is 0x%h, expected 0x%h", $time, name, got, exp);
		end
	endtask

	always @(posedge clk) begin
		addr_pkg::addr_t    addr_exp;
		addr_pkg::addr_t    vec_exp;
		irq_pkg::irq_mask_t ack_exp;
		irq_pkg::data_t     rd_exp;
		logic               hit_exp;
		int                 win;
		if (!rst_n) begin
			pc_m = `SM83_RESET_PC;
			ie_m = '0;
			if_m = '0;
		end else begin
			addr_exp = bus_disable ? '0 : pc_m;
			hit_exp  = (addr_exp == `SM83_IE_ADDR);
			rd_exp   = (rd && hit_exp) ? irq_pkg::data_t'(ie_m) : '0;
			win      = lowest_index(if_m);
			ack_exp  = '0;
			vec_exp  = `SM83_VEC_BASE;
			if (win >= 0) begin
				vec_exp = addr_pkg::addr_t'(`SM83_VEC_BASE + `SM83_VEC_STRIDE * win);
				if (irq_enable && ime) begin
					ack_exp[win] = 1'b1;
				end
			end

			check_field("addr", addr, addr_exp);
			check_field("irq_ack", 16'(irq_ack), 16'(ack_exp));
			check_field("irq_taken", 16'(irq_taken), 16'(ack_exp != '0));
			check_field("irq_pending", 16'(irq_pending), 16'(if_m != '0));
			check_field("ie_hit", 16'(ie_hit), 16'(hit_exp));
			check_field("ie_rd_data", 16'(ie_rd_data), 16'(rd_exp));

			// IF uses the IE value from before this edge
			for (int i = 0; i < `SM83_IRQ_N; i++) begin
				if (ack_exp[i]) begin
					if_m[i] = 1'b0;
				end else if (irq_trig[i] && ie_m[i]) begin
					if_m[i] = 1'b1;
				end
			end
			if (ie_wr && hit_exp) begin
				ie_m = irq_pkg::irq_mask_t'(data_in);
			end
			if (ack_exp != '0) begin
				pc_m = vec_exp;
			end else if (pc_load) begin
				pc_m = pc_load_val;
			end else begin
				pc_m = step_addr(pc_m, step_op, pair_step);
			end
		end
	end

endmodule

/* bench/sm83_bottom_tb.sv */
`timescale 1ns/1ps

module sm83_bottom_tb;

	typedef struct packed {
		addr_pkg::step_op_t op;
		logic               pair;
		logic               load;
		logic [15:0]        load_val;
		logic               dis;
		logic [7:0]         trig;
		logic               wr;
		logic [7:0]         data;
		logic               rd;
		logic               en;
		logic               ime;
		logic               rnd;   // Inputs come from $urandom
		logic [7:0]         reps;
	} row_t;

	localparam addr_pkg::step_op_t HOLD = addr_pkg::STEP_HOLD;
	localparam addr_pkg::step_op_t INC  = addr_pkg::STEP_INC;
	localparam addr_pkg::step_op_t DEC  = addr_pkg::STEP_DEC;

	logic               clk;
	logic               rst_n;
	addr_pkg::step_op_t step_op;
	logic               pair_step;
	logic               pc_load;
	addr_pkg::addr_t    pc_load_val;
	logic               bus_disable;
	irq_pkg::irq_mask_t irq_trig;
	logic               ie_wr;
	irq_pkg::data_t     data_in;
	logic               rd;
	logic               irq_enable;
	logic               ime;
	addr_pkg::addr_t    addr;
	irq_pkg::irq_mask_t irq_ack;
	logic               irq_pending;
	logic               irq_taken;
	logic               ie_hit;
	irq_pkg::data_t     ie_rd_data;
	int                 checks;
	int                 errors;
	int                 total_cycles;
	row_t               rows[$];

	sm83_bottom u_sm83_bottom (
		.clk(clk), .rst_n(rst_n), .step_op(step_op), .pair_step(pair_step),
		.pc_load(pc_load), .pc_load_val(pc_load_val), .bus_disable(bus_disable),
		.irq_trig(irq_trig), .ie_wr(ie_wr), .data_in(data_in), .rd(rd),
		.irq_enable(irq_enable), .ime(ime), .addr(addr), .irq_ack(irq_ack),
		.irq_pending(irq_pending), .irq_taken(irq_taken), .ie_hit(ie_hit),
		.ie_rd_data(ie_rd_data)
	);

	sm83_bottom_checker u_checker (
		.clk(clk), .rst_n(rst_n), .step_op(step_op), .pair_step(pair_step),
		.pc_load(pc_load), .pc_load_val(pc_load_val), .bus_disable(bus_disable),
		.irq_trig(irq_trig), .ie_wr(ie_wr), .data_in(data_in), .rd(rd),
		.irq_enable(irq_enable), .ime(ime), .addr(addr), .irq_ack(irq_ack),
		.irq_pending(irq_pending), .irq_taken(irq_taken), .ie_hit(ie_hit),
		.ie_rd_data(ie_rd_data), .check_count(checks), .error_count(errors)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic drive_row(input row_t r);
		step_op     = r.op;
		pair_step   = r.pair;
		pc_load     = r.load;
		pc_load_val = r.load_val;
		bus_disable = r.dis;
		irq_trig    = r.trig;
		ie_wr       = r.wr;
		data_in     = r.data;
		rd          = r.rd;
		irq_enable  = r.en;
		ime         = r.ime;
	endtask

	// Loads often hit 0xFFFF so IE traffic shows up
	task automatic drive_random();
		logic [31:0] r0;
		logic [31:0] r1;
		r0          = $urandom;
		r1          = $urandom;
		step_op     = (r0[1:0] == 2'b11) ? INC : addr_pkg::step_op_t'(r0[1:0]);
		pc_load     = (r0[4:2] == 3'b000);
		pc_load_val = (r0[6:5] == 2'b00) ? 16'hFFFF : r1[15:0];
		bus_disable = (r0[9:7] == 3'b000);
		irq_trig    = (r0[12:10] == 3'b000) ? r1[23:16] : 8'h00;
		ie_wr       = r0[13] & r0[14];
		data_in     = r1[31:24];
		rd          = r0[15];
		irq_enable  = (r0[18:16] != 3'b000);
		ime         = (r0[21:19] != 3'b000);
		pair_step   = r0[22];
	endtask

	initial begin
		void'($urandom(23));
		rst_n = 1'b0;
		drive_row('0);

		//                  op  pair load  load_val dis  trig  wr   data   rd  en  ime rnd reps
		rows.push_back(row_t'{HOLD, '0, '0, 16'h0000, '0, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd3});
		rows.push_back(row_t'{HOLD, '0, '1, 16'h00FE, '0, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd1});
		rows.push_back(row_t'{INC,  '0, '0, 16'h0000, '0, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd3});
		rows.push_back(row_t'{HOLD, '0, '1, 16'h0101, '0, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd1});
		rows.push_back(row_t'{DEC,  '0, '0, 16'h0000, '0, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd3});
		rows.push_back(row_t'{HOLD, '0, '1, 16'hFFFE, '0, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd1});
		rows.push_back(row_t'{INC,  '0, '0, 16'h0000, '0, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd3});
		rows.push_back(row_t'{HOLD, '0, '1, 16'h1234, '0, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd1});
		rows.push_back(row_t'{INC,  '1, '0, 16'h0000, '0, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd2});
		rows.push_back(row_t'{DEC,  '1, '0, 16'h0000, '0, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd2});
		rows.push_back(row_t'{HOLD, '0, '1, 16'h12FF, '0, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd1});
		rows.push_back(row_t'{INC,  '1, '0, 16'h0000, '0, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd1});
		// Bus blanking while the PC keeps counting
		rows.push_back(row_t'{HOLD, '0, '1, 16'h4000, '0, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd1});
		rows.push_back(row_t'{INC,  '0, '0, 16'h0000, '0, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd2});
		rows.push_back(row_t'{INC,  '0, '0, 16'h0000, '1, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd4});
		rows.push_back(row_t'{INC,  '0, '0, 16'h0000, '0, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd2});
		rows.push_back(row_t'{HOLD, '0, '1, 16'h8000, '1, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd1});
		rows.push_back(row_t'{INC,  '0, '0, 16'h0000, '0, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd1});
		// IE write and read back
		rows.push_back(row_t'{HOLD, '0, '1, 16'hFFFF, '0, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd1});
		rows.push_back(row_t'{HOLD, '0, '0, 16'h0000, '0, 8'h00, '0, 8'h00, '1, '1, '1, '0, 8'd1});
		rows.push_back(row_t'{HOLD, '0, '0, 16'h0000, '0, 8'h00, '1, 8'h1F, '0, '1, '1, '0, 8'd1});
		rows.push_back(row_t'{HOLD, '0, '0, 16'h0000, '0, 8'h00, '0, 8'h00, '1, '1, '1, '0, 8'd2});
		rows.push_back(row_t'{HOLD, '0, '0, 16'h0000, '1, 8'h00, '1, 8'hFF, '0, '1, '1, '0, 8'd1});
		rows.push_back(row_t'{HOLD, '0, '1, 16'h1000, '0, 8'h00, '0, 8'h00, '1, '1, '1, '0, 8'd1});
		rows.push_back(row_t'{HOLD, '0, '0, 16'h0000, '0, 8'h00, '1, 8'hFF, '0, '1, '1, '0, 8'd1});
		rows.push_back(row_t'{HOLD, '0, '0, 16'h0000, '0, 8'h00, '0, 8'h00, '1, '1, '1, '0, 8'd1});
		rows.push_back(row_t'{HOLD, '0, '1, 16'hFFFF, '0, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd1});
		rows.push_back(row_t'{HOLD, '0, '0, 16'h0000, '0, 8'h00, '0, 8'h00, '1, '1, '1, '0, 8'd1});
		// Pending while masked and bit 5 not enabled in IE
		rows.push_back(row_t'{HOLD, '0, '0, 16'h0000, '0, 8'h25, '0, 8'h00, '0, '1, '0, '0, 8'd1});
		rows.push_back(row_t'{HOLD, '0, '0, 16'h0000, '0, 8'h00, '0, 8'h00, '0, '1, '0, '0, 8'd3});
		rows.push_back(row_t'{HOLD, '0, '0, 16'h0000, '0, 8'h00, '0, 8'h00, '0, '0, '1, '0, 8'd3});
		rows.push_back(row_t'{HOLD, '0, '0, 16'h0000, '0, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd6});
		rows.push_back(row_t'{INC,  '0, '0, 16'h0000, '0, 8'h18, '0, 8'h00, '0, '1, '1, '0, 8'd1});
		rows.push_back(row_t'{INC,  '0, '0, 16'h0000, '0, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd5});
		rows.push_back(row_t'{HOLD, '0, '0, 16'h0000, '0, 8'h00, '0, 8'h00, '0, '1, '1, '1, 8'd200});
		rows.push_back(row_t'{HOLD, '0, '0, 16'h0000, '0, 8'h00, '0, 8'h00, '0, '1, '1, '0, 8'd2});

		total_cycles = 0;
		foreach (rows[i]) begin
			total_cycles += int'(rows[i].reps);
		end

		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		foreach (rows[i]) begin
			for (int n = 0; n < int'(rows[i].reps); n++) begin
				if (rows[i].rnd) begin
					drive_random();
				end else begin
					drive_row(rows[i]);
				end
				@(negedge clk);
			end
		end
		drive_row('0);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// Table length plus margin for reset and the closing cycles
	initial begin
		#1;
		#((total_cycles + 20) * 10);
		$display("Timeout: stimulus did not finish within %0d cycles", total_cycles + 20);
		$display("Test failures found");
		$finish;
	end

endmodule

/* design/addr_incdec.sv */
`timescale 1ns/1ps

module addr_incdec (
	input  logic               clk,        // Assertion sampling only
	input  logic               rst_n,
	input  addr_pkg::addr_t    pc,
	input  addr_pkg::step_op_t step_op,
	input  logic               pair_step,  // Force a step into the high byte
	output addr_pkg::addr_t    stepped
);

	localparam int ADDR_W = $bits(addr_pkg::addr_t);
	localparam int HALF   = ADDR_W / 2;

	logic            inc;
	logic            dec;
	logic            step_lo;   // Carry into bit 0
	logic            wrap_lo;   // Low byte wrapped
	logic            carry_hi;  // Carry into the high byte
	addr_pkg::addr_t prop;      // Per-bit propagate
	addr_pkg::addr_t cin;       // Per-bit carry or borrow in

	assign inc     = (step_op == addr_pkg::STEP_INC);
	assign dec     = (step_op == addr_pkg::STEP_DEC);
	assign step_lo = inc | dec;

	// A set bit passes an increment on and a clear bit passes a decrement on
	always_comb begin
		for (int i = 0; i < ADDR_W; i++) begin
			prop[i] = pc[i] ? inc : dec;
		end
	end

	always_comb begin
		cin[0] = step_lo;
		for (int i = 1; i < HALF; i++) begin
			cin[i] = cin[i-1] & prop[i-1];
		end
		wrap_lo  = cin[HALF-1] & prop[HALF-1];  // 0xFF->0x00 or 0x00->0xFF
		carry_hi = step_lo & (wrap_lo | pair_step);
		cin[HALF] = carry_hi;
		for (int i = HALF + 1; i < ADDR_W; i++) begin
			cin[i] = cin[i-1] & prop[i-1];
		end
	end

	assign stepped = pc ^ cin;  // Toggle every bit that receives a carry

	a_hold_keeps_pc: assert property (
		@(posedge clk) disable iff (!rst_n)
		(step_op == addr_pkg::STEP_HOLD) |-> (stepped == pc)
	) else $error("HOLD changed the address");

	a_step_op_legal: assert property (
		@(posedge clk) disable iff (!rst_n)
		step_op inside {addr_pkg::STEP_HOLD, addr_pkg::STEP_INC, addr_pkg::STEP_DEC}
	) else $error("Unused step encoding");

	// Pair mode always moves the high byte by exactly one
	a_pair_moves_high: assert property (
		@(posedge clk) disable iff (!rst_n)
		(inc && pair_step) |->
			(stepped[ADDR_W-1:HALF] == pc[ADDR_W-1:HALF] + (ADDR_W-HALF)'(1))
	) else $error("Pair increment missed the high byte");

endmodule

/* design/addr_pkg.sv */
`include "sm83_defines.svh"

// Address side types
package addr_pkg;

	// Full external address
	typedef logic [`SM83_ADDR_W-1:0] addr_t;

	// What the incrementer does this cycle
	typedef enum logic [1:0] {
		STEP_HOLD = 2'b00,  // Pass through
		STEP_INC  = 2'b01,  // +1
		STEP_DEC  = 2'b10   // -1
	} step_op_t;

endpackage

/* design/irq_ctrl.sv */
`timescale 1ns/1ps

`include "sm83_defines.svh"

module irq_ctrl (
	input  logic               clk,
	input  logic               rst_n,
	input  addr_pkg::addr_t    addr,        // Driven address bus
	input  irq_pkg::irq_mask_t irq_trig,
	input  logic               ie_wr,       // Write strobe for IE
	input  irq_pkg::data_t     data_in,
	input  logic               rd,
	input  logic               irq_enable,  // Sequencer allows servicing
	input  logic               ime,         // Master enable
	output irq_pkg::irq_mask_t irq_ack,
	output logic               irq_taken,
	output addr_pkg::addr_t    irq_vector,
	output logic               irq_pending,
	output logic               ie_hit,
	output irq_pkg::data_t     ie_rd_data
);

	localparam int IRQ_N = $bits(irq_pkg::irq_mask_t);

	irq_pkg::irq_mask_t ie_q;
	irq_pkg::irq_mask_t if_q;
	irq_pkg::irq_mask_t if_next;
	irq_pkg::irq_mask_t lowest;    // Lowest set IF bit, one-hot
	irq_pkg::irq_idx_t  win_idx;
	logic               allow;

	// IE access decode
	assign ie_hit     = (addr == `SM83_IE_ADDR);
	assign ie_rd_data = (rd && ie_hit) ? irq_pkg::data_t'(ie_q) : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ie_q <= '0;
		end else if (ie_wr && ie_hit) begin
			ie_q <= irq_pkg::irq_mask_t'(data_in);
		end
	end

	// Acknowledge wins over a new trigger on the same bit
	assign if_next = ~irq_ack & (if_q | (irq_trig & ie_q));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			if_q <= '0;
		end else begin
			if_q <= if_next;
		end
	end

	// Priority encoder, scan from the top so bit 0 ends up winning
	always_comb begin
		lowest  = '0;
		win_idx = '0;
		for (int i = IRQ_N - 1; i >= 0; i--) begin
			if (if_q[i]) begin
				lowest  = irq_pkg::irq_mask_t'(1) << i;
				win_idx = irq_pkg::irq_idx_t'(i);
			end
		end
	end

	assign allow       = irq_enable & ime;
	assign irq_ack     = allow ? lowest : '0;
	assign irq_taken   = |irq_ack;
	assign irq_pending = |if_q;

	// Vector = base + stride * index
	assign irq_vector = `SM83_VEC_BASE + `SM83_VEC_STRIDE * addr_pkg::addr_t'(win_idx);

	a_ack_onehot: assert property (
		@(posedge clk) disable iff (!rst_n)
		$onehot0(irq_ack)
	) else $error("More than one acknowledge active");

	a_ack_clears_if: assert property (
		@(posedge clk) disable iff (!rst_n)
		(irq_ack != '0) |=> ((if_q & $past(irq_ack)) == '0)
	) else $error("Acknowledged IF bit still set");

endmodule

/* design/irq_pkg.sv */
`include "sm83_defines.svh"

// Interrupt side types
package irq_pkg;

	// Byte on the data bus
	typedef logic [`SM83_DATA_W-1:0] data_t;

	// One bit per source, bit 0 has highest priority
	typedef logic [`SM83_IRQ_N-1:0] irq_mask_t;

	// Index of the winning source
	typedef logic [$clog2(`SM83_IRQ_N)-1:0] irq_idx_t;

endpackage

/* design/pc_sequencer.sv */
`timescale 1ns/1ps

`include "sm83_defines.svh"

module pc_sequencer (
	input  logic            clk,
	input  logic            rst_n,
	input  addr_pkg::addr_t stepped,      // From the incrementer
	input  logic            irq_taken,
	input  addr_pkg::addr_t irq_vector,
	input  logic            pc_load,
	input  addr_pkg::addr_t pc_load_val,
	input  logic            bus_disable,  // Blank the external bus
	output addr_pkg::addr_t pc,
	output addr_pkg::addr_t addr
);

	addr_pkg::addr_t pc_next;

	// Vector beats load and load beats step
	always_comb begin
		if (irq_taken) begin
			pc_next = irq_vector;
		end else if (pc_load) begin
			pc_next = pc_load_val;
		end else begin
			pc_next = stepped;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= `SM83_RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

	// PC keeps running behind a blanked bus
	assign addr = bus_disable ? '0 : pc;

	a_bus_blank: assert property (
		@(posedge clk) disable iff (!rst_n)
		bus_disable |-> (addr == '0)
	) else $error("Address bus not blanked");

endmodule

/* design/sm83_bottom.sv */
`timescale 1ns/1ps

module sm83_bottom (
	input  logic               clk,
	input  logic               rst_n,
	input  addr_pkg::step_op_t step_op,
	input  logic               pair_step,
	input  logic               pc_load,
	input  addr_pkg::addr_t    pc_load_val,
	input  logic               bus_disable,
	input  irq_pkg::irq_mask_t irq_trig,
	input  logic               ie_wr,
	input  irq_pkg::data_t     data_in,
	input  logic               rd,
	input  logic               irq_enable,
	input  logic               ime,
	output addr_pkg::addr_t    addr,
	output irq_pkg::irq_mask_t irq_ack,
	output logic               irq_pending,
	output logic               irq_taken,
	output logic               ie_hit,
	output irq_pkg::data_t     ie_rd_data
);

	addr_pkg::addr_t pc;          // Current program counter
	addr_pkg::addr_t stepped;     // PC after inc/dec
	addr_pkg::addr_t irq_vector;

	addr_incdec u_addr_incdec (
		.clk       (clk),
		.rst_n     (rst_n),
		.pc        (pc),
		.step_op   (step_op),
		.pair_step (pair_step),
		.stepped   (stepped)
	);

	irq_ctrl u_irq_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.addr        (addr),
		.irq_trig    (irq_trig),
		.ie_wr       (ie_wr),
		.data_in     (data_in),
		.rd          (rd),
		.irq_enable  (irq_enable),
		.ime         (ime),
		.irq_ack     (irq_ack),
		.irq_taken   (irq_taken),
		.irq_vector  (irq_vector),
		.irq_pending (irq_pending),
		.ie_hit      (ie_hit),
		.ie_rd_data  (ie_rd_data)
	);

	pc_sequencer u_pc_sequencer (
		.clk         (clk),
		.rst_n       (rst_n),
		.stepped     (stepped),
		.irq_taken   (irq_taken),
		.irq_vector  (irq_vector),
		.pc_load     (pc_load),
		.pc_load_val (pc_load_val),
		.bus_disable (bus_disable),
		.pc          (pc),
		.addr        (addr)
	);

endmodule

/* design/sm83_defines.svh */
`ifndef SM83_DEFINES_SVH
`define SM83_DEFINES_SVH

// Datapath widths
`define SM83_ADDR_W      16
`define SM83_DATA_W      8

// Interrupt sources, one IE/IF bit each
`define SM83_IRQ_N       8

// Program counter value after reset
`define SM83_RESET_PC    16'h0000

// IE register sits at the top of the address space
`define SM83_IE_ADDR     16'hFFFF

// Interrupt 0 jumps here
`define SM83_VEC_BASE    16'h0040

// Spacing between consecutive vectors
`define SM83_VEC_STRIDE  16'd8

`endif

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sm83_bottom.f --top-module sm83_bottom_tb \
	-Mdir obj_dir -o sm83_bottom_sim > build.log 2>&1 \
	&& ./obj_dir/sm83_bottom_sim > sim.log 2>&1 \
	; grep -q "All tests passed!" sim.log \
	&& echo "Simulation PASSED" \
	|| { echo "Simulation FAILED, see build.log and sim.log"; exit 1; }

/* sm83_bottom.f */
+incdir+design
design/addr_pkg.sv
design/irq_pkg.sv
design/addr_incdec.sv
design/irq_ctrl.sv
design/pc_sequencer.sv
design/sm83_bottom.sv
bench/sm83_bottom_checker.sv
bench/sm83_bottom_tb.sv
